//--- source/nd_bus_pkg.sv
/* ND bus package
   APB data and address widths, register map and the bus-side state types */
package nd_bus_pkg;

  localparam int data_w = 16;                    // APB data width
  localparam int addr_w = 12;                    // APB word address width

  typedef logic [data_w-1:0] bus_data_t;         // One bus word
  typedef logic [addr_w-1:0] bus_addr_t;         // One word address

  // Region bases in the word address space
  localparam bus_addr_t cs_base   = 12'h000;     // Control store quarters
  localparam bus_addr_t pt_base   = 12'h400;     // Page table entries
  localparam bus_addr_t ctrl_addr = 12'h800;     // Control register
  localparam bus_addr_t stat_addr = 12'h801;     // Status register

  localparam int cs_aw     = 10;                 // Control store region, 1024 locations
  localparam int cs_qsel_w = 2;                  // Quarter select, low address bits
  localparam int pt_aw     = 6;                  // Page table region, 64 entries

  // Control register fields
  localparam int ctrl_start_bit = 0;             // Start pulse, not stored
  localparam int ctrl_map_bit   = 1;             // Map enable
  localparam int ctrl_sa_lsb    = 8;             // Start address, bits 15..8

  // Status register fields
  localparam int stat_run_bit  = 0;              // Sequencer running
  localparam int stat_halt_bit = 1;              // Sequencer halted
  localparam int stat_ua_lsb   = 8;              // Current micro address

  typedef enum logic [1:0] {
    idle,                                        // No transfer
    setup,                                       // psel without penable
    access,                                      // First access cycle
    wait_rd                                      // Read wait state done, data out
  } apb_state_t;

  typedef enum logic [2:0] {
    reg_none,                                    // Outside the map
    reg_cs,
    reg_pt,
    reg_ctrl,
    reg_stat
  } region_t;

endpackage

//--- source/nd_cpu_pkg.sv
/* ND CPU package
   Control store, microsequencer and MMU sizes, fields and state types */
package nd_cpu_pkg;

  // Control store
  localparam int cs_depth = 256;                 // Microwords
  localparam int uaddr_w  = 8;                   // Micro address width
  localparam int csword_w = 64;                  // Microword width

  typedef logic [uaddr_w-1:0]  uaddr_t;
  typedef logic [csword_w-1:0] csword_t;

  // Microword fields
  localparam int op_msb  = 63;                   // Sequencing opcode, top two bits
  localparam int op_lsb  = 62;
  localparam int jmp_lsb = 0;                    // Jump target, bits 7..0

  // Sequencing opcode, 2'b11 decodes as next
  typedef enum logic [1:0] {
    op_next = 2'b00,
    op_jump = 2'b01,
    op_halt = 2'b10
  } useq_op_t;

  // MMU
  localparam int page_w       = 14;              // Logical and physical page width
  localparam int pt_depth     = 64;              // Page table entries
  localparam int pt_idx_w     = $clog2(pt_depth); // Index from la bits 5..0
  localparam int pt_entry_w   = page_w + 1;      // Valid bit over page
  localparam int pt_valid_bit = page_w;          // Bit 14

  typedef logic [page_w-1:0]     page_t;
  typedef logic [pt_entry_w-1:0] pt_entry_t;

  // Microsequencer
  typedef enum logic [1:0] {
    seq_idle,                                    // Never started
    seq_run,                                     // Fetching microwords
    seq_halted                                   // Stopped on a halt word
  } seq_state_t;

endpackage

//--- source/apb_ctrl_fsm.sv
/* APB control FSM
   Decodes APB transfers, drives RAM strobes, holds control and merges read data */
module apb_ctrl_fsm (
  input  logic                                sysclk,
  input  logic                                arst_n,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  nd_bus_pkg::bus_addr_t               paddr,
  input  nd_bus_pkg::bus_data_t               pwdata,
  input  nd_bus_pkg::bus_data_t               cs_rdata,
  input  nd_bus_pkg::bus_data_t               pt_rdata,
  input  logic                                running,
  input  logic                                halted,
  input  nd_cpu_pkg::uaddr_t                  uaddr,
  output nd_bus_pkg::bus_data_t               prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic                                cs_we,
  output logic                                cs_re,
  output logic                                pt_we,
  output logic                                pt_re,
  output logic [nd_bus_pkg::cs_aw-1:0]        ram_addr,
  output nd_bus_pkg::bus_data_t               wdata,
  output logic                                start,
  output nd_cpu_pkg::uaddr_t                  start_addr,
  output logic                                map_en
);
  import nd_bus_pkg::*;
  import nd_cpu_pkg::*;

  apb_state_t state;                             // Bus phase of this cycle
  region_t    region;                            // Decoded target
  logic       rd_wait_q;                         // Read sampled by RAMs last cycle
  logic       err;                               // Transfer gets an error response
  logic       ctrl_wr;                           // Control register write strobe
  bus_data_t  ctrl_word;                         // Control readback
  bus_data_t  stat_word;                         // Status readback
  bus_data_t  reg_rdata_q;                       // Register read source, zero when idle

  // Phase follows psel/penable; a read holds one extra cycle
  always_comb begin
    if (!psel)          state = idle;
    else if (!penable)  state = setup;
    else if (rd_wait_q) state = wait_rd;
    else                state = access;
  end

  always_comb begin
    if (paddr[addr_w-1:cs_aw] == cs_base[addr_w-1:cs_aw])      region = reg_cs;
    else if (paddr[addr_w-1:pt_aw] == pt_base[addr_w-1:pt_aw]) region = reg_pt;
    else if (paddr == ctrl_addr)                               region = reg_ctrl;
    else if (paddr == stat_addr)                               region = reg_stat;
    else                                                       region = reg_none;
  end

  // Unmapped, or microcode write under a live sequencer
  assign err = (region == reg_none) || (pwrite && region == reg_cs && running);

  // Writes land at the end of the first access cycle
  assign cs_we   = state == access && pwrite && region == reg_cs && !pslverr;
  assign pt_we   = state == access && pwrite && region == reg_pt;
  assign ctrl_wr = state == access && pwrite && region == reg_ctrl;
  // RAMs sample reads at the same edge, data is out during wait_rd
  assign cs_re   = state == access && !pwrite && region == reg_cs;
  assign pt_re   = state == access && !pwrite && region == reg_pt;

  assign ram_addr = paddr[cs_aw-1:0];
  assign wdata    = pwdata;

  always_comb begin
    ctrl_word = '0;
    ctrl_word[ctrl_map_bit] = map_en;
    ctrl_word[ctrl_sa_lsb +: uaddr_w] = start_addr;
    stat_word = '0;
    stat_word[stat_run_bit]  = running;
    stat_word[stat_halt_bit] = halted;
    stat_word[stat_ua_lsb +: uaddr_w] = uaddr;
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_wait_q   <= 1'b0;
      pready      <= 1'b0;
      pslverr     <= 1'b0;
      reg_rdata_q <= '0;
    end else begin
      rd_wait_q <= state == access && !pwrite;
      // Write done next cycle, read one cycle later
      pready    <= (state == setup && pwrite) || (state == access && !pwrite);
      pslverr   <= (state == setup && pwrite && err) || (state == access && !pwrite && err);
      if (state == access && !pwrite && region == reg_ctrl) begin
        reg_rdata_q <= ctrl_word;
      end else if (state == access && !pwrite && region == reg_stat) begin
        reg_rdata_q <= stat_word;
      end else begin
        reg_rdata_q <= '0;                       // Keeps the OR merge clean
      end
    end
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      start      <= 1'b0;
      start_addr <= '0;
      map_en     <= 1'b0;
    end else begin
      start <= ctrl_wr && pwdata[ctrl_start_bit]; // One-cycle pulse after the write
      if (ctrl_wr) begin
        map_en     <= pwdata[ctrl_map_bit];
        start_addr <= pwdata[ctrl_sa_lsb +: uaddr_w];
      end
    end
  end

  // Wired-OR read bus, every source drives zero when not selected
  assign prdata = cs_rdata | pt_rdata | reg_rdata_q;

  a_pready_phase: assert property (@(posedge sysclk) disable iff (!arst_n)
    pready |-> (state == access || state == wait_rd));

endmodule

//--- source/micro_seq_counter.sv
/* Microsequencer
   Walks the control store with next, jump and halt and registers each microword */
module micro_seq_counter (
  input  logic                sysclk,
  input  logic                arst_n,
  input  logic                start,
  input  nd_cpu_pkg::uaddr_t  start_addr,
  input  nd_cpu_pkg::csword_t fetched,
  output nd_cpu_pkg::uaddr_t  uaddr,
  output nd_cpu_pkg::csword_t csbits,
  output logic                csbits_valid,
  output logic                running,
  output logic                halted
);
  import nd_cpu_pkg::*;

  seq_state_t state_q;                           // Sequencer state
  seq_state_t state_d;
  uaddr_t     uaddr_q;                           // Micro program counter
  uaddr_t     uaddr_d;
  useq_op_t   op;                                // Opcode of the word being fetched
  uaddr_t     jump_target;

  assign op          = useq_op_t'(fetched[op_msb:op_lsb]);
  assign jump_target = fetched[jmp_lsb +: uaddr_w];

  always_comb begin
    state_d = state_q;
    uaddr_d = uaddr_q;
    if (start) begin
      state_d = seq_run;                         // Restart wins over any opcode
      uaddr_d = start_addr;
    end else if (state_q == seq_run) begin
      case (op)
        op_jump: uaddr_d = jump_target;
        op_halt: state_d = seq_halted;           // Counter stays on the halt word
        default: uaddr_d = uaddr_t'(uaddr_q + 1'b1); // Next, and the spare code
      endcase
    end
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q      <= seq_idle;
      uaddr_q      <= '0;
      csbits_valid <= 1'b0;
    end else begin
      state_q      <= state_d;
      uaddr_q      <= uaddr_d;
      csbits_valid <= state_q == seq_run;        // One word per running cycle
    end
  end

  // Microword pipeline register, holds the last word after a halt
  always_ff @(posedge sysclk) begin
    if (state_q == seq_run) begin
      csbits <= fetched;
    end
  end

  assign uaddr   = uaddr_q;
  assign running = state_q == seq_run;
  assign halted  = state_q == seq_halted;

  a_run_halt_excl: assert property (@(posedge sysclk) disable iff (!arst_n)
    !(running && halted));

endmodule

//--- source/control_store.sv
/* Writable control store
   256 x 64 microcode RAM, quarter-word APB access and a microword fetch port */
module control_store (
  input  logic                          sysclk,
  input  logic                          arst_n,
  input  logic                          we,
  input  logic                          re,
  input  logic [nd_bus_pkg::cs_aw-1:0]  addr,
  input  nd_bus_pkg::bus_data_t         wdata,
  input  nd_cpu_pkg::uaddr_t            uaddr,
  output nd_bus_pkg::bus_data_t         rdata,
  output nd_cpu_pkg::csword_t           uword
);
  import nd_bus_pkg::*;
  import nd_cpu_pkg::*;

  csword_t                mem [cs_depth];        // Microcode words
  uaddr_t                 word_sel;              // APB word index, addr 9..2
  logic [cs_qsel_w-1:0]   quarter_sel;           // Quarter 0 is bits 15..0
  csword_t                cur_word;              // Word under the APB address

  assign word_sel    = addr[cs_aw-1:cs_qsel_w];
  assign quarter_sel = addr[cs_qsel_w-1:0];
  assign cur_word    = mem[word_sel];

  // Quarter write, the other three quarters keep their bits
  always_ff @(posedge sysclk) begin
    if (we) begin
      mem[word_sel][quarter_sel*data_w +: data_w] <= wdata;
    end
  end

  // APB readback, zero unless selected so it can be ORed onto the bus
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= cur_word[quarter_sel*data_w +: data_w];
    end else begin
      rdata <= '0;
    end
  end

  // Fetch port for the sequencer, registered downstream
  assign uword = mem[uaddr];

endmodule

//--- source/page_table_mmu.sv
/* Page table MMU
   64-entry page table with APB access and a registered logical to physical map */
module page_table_mmu (
  input  logic                          sysclk,
  input  logic                          arst_n,
  input  logic                          we,
  input  logic                          re,
  input  logic [nd_bus_pkg::pt_aw-1:0]  addr,
  input  nd_bus_pkg::bus_data_t         wdata,
  input  logic                          map_en,
  input  nd_cpu_pkg::page_t             la,
  output nd_bus_pkg::bus_data_t         rdata,
  output nd_cpu_pkg::page_t             ppn,
  output logic                          page_fault
);
  import nd_bus_pkg::*;
  import nd_cpu_pkg::*;

  pt_entry_t table_q [pt_depth];                 // Valid bit over physical page
  pt_entry_t entry;                              // Entry for the current la
  logic      entry_valid;
  page_t     entry_page;

  always_ff @(posedge sysclk) begin
    if (we) begin
      table_q[addr] <= wdata[pt_entry_w-1:0];    // Bit 15 of the bus word is dropped
    end
  end

  // APB readback, zero unless selected
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= bus_data_t'(table_q[addr]);
    end else begin
      rdata <= '0;
    end
  end

  assign entry       = table_q[la[pt_idx_w-1:0]]; // Low page bits index the table
  assign entry_valid = entry[pt_valid_bit];
  assign entry_page  = entry[page_w-1:0];

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      ppn        <= '0;
      page_fault <= 1'b0;
    end else if (!map_en) begin
      ppn        <= la;                          // Mapping off, page passes straight
      page_fault <= 1'b0;
    end else if (entry_valid) begin
      ppn        <= entry_page;
      page_fault <= 1'b0;
    end else begin
      ppn        <= '0;                          // Missing entry
      page_fault <= 1'b1;
    end
  end

  // Fault flags only a lookup made with mapping on
  a_fault_needs_map: assert property (@(posedge sysclk) disable iff (!arst_n)
    page_fault |-> $past(map_en));

endmodule

//--- source/cpu_core_top.sv
/* CPU core top
   Connects APB control, microsequencer, control store and page table MMU */
module cpu_core_top (
  input  logic                  sysclk,
  input  logic                  arst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  nd_bus_pkg::bus_addr_t paddr,
  input  nd_bus_pkg::bus_data_t pwdata,
  input  nd_cpu_pkg::page_t     la,
  output nd_bus_pkg::bus_data_t prdata,
  output logic                  pready,
  output logic                  pslverr,
  output nd_cpu_pkg::csword_t   csbits,
  output logic                  csbits_valid,
  output logic                  running,
  output nd_cpu_pkg::page_t     ppn,
  output logic                  page_fault
);
  import nd_bus_pkg::*;
  import nd_cpu_pkg::*;

  bus_data_t         cs_rdata;                   // Zero when not read
  bus_data_t         pt_rdata;                   // Zero when not read
  logic              cs_we;
  logic              cs_re;
  logic              pt_we;
  logic              pt_re;
  logic [cs_aw-1:0]  ram_addr;                   // Shared RAM address
  bus_data_t         wdata;
  logic              start;
  uaddr_t            start_addr;
  logic              map_en;
  logic              halted;
  uaddr_t            uaddr;
  csword_t           uword;                      // Fetched microword

  apb_ctrl_fsm i_apb_ctrl_fsm (
    .sysclk     (sysclk),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .cs_rdata   (cs_rdata),
    .pt_rdata   (pt_rdata),
    .running    (running),
    .halted     (halted),
    .uaddr      (uaddr),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .cs_we      (cs_we),
    .cs_re      (cs_re),
    .pt_we      (pt_we),
    .pt_re      (pt_re),
    .ram_addr   (ram_addr),
    .wdata      (wdata),
    .start      (start),
    .start_addr (start_addr),
    .map_en     (map_en)
  );

  micro_seq_counter i_micro_seq_counter (
    .sysclk       (sysclk),
    .arst_n       (arst_n),
    .start        (start),
    .start_addr   (start_addr),
    .fetched      (uword),
    .uaddr        (uaddr),
    .csbits       (csbits),
    .csbits_valid (csbits_valid),
    .running      (running),
    .halted       (halted)
  );

  control_store i_control_store (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .we     (cs_we),
    .re     (cs_re),
    .addr   (ram_addr),
    .wdata  (wdata),
    .uaddr  (uaddr),
    .rdata  (cs_rdata),
    .uword  (uword)
  );

  page_table_mmu i_page_table_mmu (
    .sysclk     (sysclk),
    .arst_n     (arst_n),
    .we         (pt_we),
    .re         (pt_re),
    .addr       (ram_addr[pt_aw-1:0]),
    .wdata      (wdata),
    .map_en     (map_en),
    .la         (la),
    .rdata      (pt_rdata),
    .ppn        (ppn),
    .page_fault (page_fault)
  );

endmodule

//--- tests/tb_cpu_core.sv
/* CPU core testbench
   Directed APB tests of the control store, page table MMU and microsequencer */
module tb_cpu_core;
  import nd_bus_pkg::*;
  import nd_cpu_pkg::*;

  localparam int clk_per  = 8;
  localparam int poll_max = 64;                  // Handshake timeout in cycles
  localparam int n_cs_rw  = 24;                  // Random control store quarters
  localparam int n_pt_rw  = 16;                  // Random page table entries
  localparam int xfer_cyc = 5;                   // One APB transfer with idle cycle
  localparam int test_cyc = 10 + (2 * (n_cs_rw + n_pt_rw) + 2) * xfer_cyc
                          + 6 * xfer_cyc + 4 + 26 * xfer_cyc + 2 * poll_max
                          + 12 * xfer_cyc + 2 * poll_max;
  localparam int wd_time  = 4 * test_cyc * clk_per; // Margin of four over the tests

  logic        sysclk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  bus_addr_t   paddr;
  bus_data_t   pwdata;
  page_t       la;
  bus_data_t   prdata;
  logic        pready;
  logic        pslverr;
  csword_t     csbits;
  logic        csbits_valid;
  logic        running;
  page_t       ppn;
  logic        page_fault;

  logic [31:0] lfsr_state;                       // Galois LFSR, one step per bit
  int          err_cnt;                          // Errors in the running test
  int          total_err;
  int          tests_run;
  int          tests_failed;
  csword_t     prog [cs_depth];                  // Reference copy of loaded microcode
  csword_t     exp_q [$];                        // Predicted microword walk
  uaddr_t      exp_last;                         // Address of the predicted halt word
  csword_t     seen_q [$];                       // csbits seen with csbits_valid
  logic        capture_on;

  cpu_core_top i_cpu_core_top (
    .sysclk       (sysclk),
    .arst_n       (arst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .la           (la),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .csbits       (csbits),
    .csbits_valid (csbits_valid),
    .running      (running),
    .ppn          (ppn),
    .page_fault   (page_fault)
  );

  initial begin
    sysclk = 1'b0;
    forever #(clk_per / 2) sysclk = ~sysclk;
  end

  // Microword monitor, outputs settle well before the falling edge
  always @(negedge sysclk) begin
    if (capture_on && csbits_valid) begin
      seen_q.push_back(csbits);
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};              // Take the bit shifted out
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  function automatic bus_addr_t cs_addr(input uaddr_t word, input logic [1:0] quarter);
    return cs_base + {2'b00, word, quarter};     // Word in 9..2, quarter in 1..0
  endfunction

  function automatic csword_t make_uword(input logic [1:0] op, input uaddr_t target);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(30);
    lo = rand_bits(24);
    return {op, hi[29:0], lo[23:0], target};     // Opcode on top, target at the bottom
  endfunction

  // Walk by the opcode rules: 01 jumps, 10 halts, anything else steps
  function automatic void predict_walk(input uaddr_t first);
    uaddr_t  a;
    csword_t w;
    int      steps;
    exp_q.delete();
    a = first;
    for (steps = 0; steps < cs_depth; steps++) begin
      w = prog[a];
      exp_q.push_back(w);
      exp_last = a;
      if (w[63:62] == 2'b10) begin
        break;
      end else if (w[63:62] == 2'b01) begin
        a = w[7:0];
      end else begin
        a = a + 8'd1;
      end
    end
  endfunction

  task automatic check_data(input bus_data_t got, input bus_data_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_word(input csword_t got, input csword_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_page(input page_t got, input page_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic apb_xfer(input logic wr, input bus_addr_t addr, input bus_data_t data,
                          output bus_data_t rdata, output logic err);
    int waits;
    waits = 0;
    rdata = '0;
    err   = 1'b0;
    @(negedge sysclk);
    psel    = 1'b1;                              // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge sysclk);
    penable = 1'b1;                              // Access phase
    while (!pready && waits < poll_max) begin
      @(negedge sysclk);
      waits++;
    end
    if (!pready) begin
      $display("APB transfer to address %h never got pready", addr);
      err_cnt++;
    end else begin
      if (waits != (wr ? 0 : 1)) begin
        $display("ERROR %0t: APB transfer at %h took %0d wait states", $time, addr, waits);
        err_cnt++;
      end
      rdata = prdata;
      err   = pslverr;
    end
    @(negedge sysclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input bus_addr_t addr, input bus_data_t data, output logic err);
    bus_data_t unused_rd;
    apb_xfer(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input bus_addr_t addr, output bus_data_t data, output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic load_word(input uaddr_t w, input csword_t v);
    logic e;
    int   q;
    for (q = 0; q < 4; q++) begin
      apb_write(cs_addr(w, q[1:0]), v[q*data_w +: data_w], e);
      check_data({15'b0, e}, '0, "pslverr on microcode load");
    end
    prog[w] = v;
  endtask

  task automatic wait_running(input logic level, input string what);
    int n;
    n = 0;
    while (running !== level && n < poll_max) begin
      @(negedge sysclk);
      n++;
    end
    if (running !== level) begin
      $display("Sequencer did not %s within %0d cycles", what, poll_max);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt != 0) begin
      tests_failed++;
    end
    total_err += err_cnt;
    $display("%s: %s, %0d errors", name, (err_cnt == 0) ? "ok" : "failed", err_cnt);
    err_cnt = 0;
  endtask

  task automatic test_reset_state();
    bus_data_t d;
    logic      e;
    check_data({11'b0, pready, running, csbits_valid, page_fault, pslverr}, '0,
               "flags after reset");
    apb_read(stat_addr, d, e);
    check_data(d, '0, "status after reset");
    check_data({15'b0, e}, '0, "pslverr on status read");
    end_test("reset_state");
  endtask

  task automatic test_ram_readback();
    bus_addr_t addrs [$];
    bus_data_t model [bus_addr_t];               // Last value per address
    bus_addr_t a;
    bus_data_t v;
    bus_data_t d;
    logic      e;
    int        i;
    for (i = 0; i < n_cs_rw; i++) begin
      a = cs_base + bus_addr_t'(rand_bits(10));
      v = bus_data_t'(rand_bits(16));
      apb_write(a, v, e);
      check_data({15'b0, e}, '0, "pslverr on control store write");
      model[a] = v;
      addrs.push_back(a);
    end
    for (i = 0; i < n_pt_rw; i++) begin
      a = pt_base + bus_addr_t'(rand_bits(6));
      v = bus_data_t'(rand_bits(16));
      apb_write(a, v, e);
      check_data({15'b0, e}, '0, "pslverr on page table write");
      model[a] = {1'b0, v[14:0]};                // Entry is 15 bits wide
      addrs.push_back(a);
    end
    for (i = 0; i < addrs.size(); i++) begin
      apb_read(addrs[i], d, e);
      check_data(d, model[addrs[i]], "RAM readback");
      check_data({15'b0, e}, '0, "pslverr on RAM read");
    end
    apb_read(12'h802, d, e);                     // Hole just above status
    check_data(d, '0, "unmapped read data");
    check_data({15'b0, e}, 16'h0001, "pslverr on unmapped read");
    end_test("ram_readback");
  endtask

  task automatic test_mmu_translate();
    page_t       l;
    page_t       p_ok;
    logic [31:0] r;
    logic        e;
    @(negedge sysclk);
    l  = page_t'(rand_bits(14));
    la = l;
    @(negedge sysclk);
    check_page(ppn, l, "ppn with mapping off");
    check_data({15'b0, page_fault}, '0, "page_fault with mapping off");
    p_ok = page_t'(rand_bits(14));
    apb_write(pt_base + 12'd5, {1'b0, 1'b1, p_ok}, e); // Valid entry
    apb_write(pt_base + 12'd9, 16'h0000, e);     // Invalid entry
    apb_write(ctrl_addr, 16'h0002, e);           // Map enable only
    r  = rand_bits(8);
    la = {r[7:0], 6'd5};
    @(negedge sysclk);
    check_page(ppn, p_ok, "ppn of a valid entry");
    check_data({15'b0, page_fault}, '0, "page_fault on a valid entry");
    r  = rand_bits(8);
    la = {r[7:0], 6'd9};
    @(negedge sysclk);
    check_page(ppn, '0, "ppn of an invalid entry");
    check_data({15'b0, page_fault}, 16'h0001, "page_fault on an invalid entry");
    apb_write(ctrl_addr, 16'h0000, e);
    la = '0;
    end_test("mmu_translate");
  endtask

  task automatic test_program_walk();
    bus_data_t d;
    logic      e;
    int        base;
    int        i;
    load_word(8'h20, make_uword(2'b00, uaddr_t'(rand_bits(8))));
    load_word(8'h21, make_uword(2'b11, uaddr_t'(rand_bits(8)))); // Spare code steps
    load_word(8'h22, make_uword(2'b00, uaddr_t'(rand_bits(8))));
    load_word(8'h23, make_uword(2'b01, 8'h40));
    load_word(8'h40, make_uword(2'b00, uaddr_t'(rand_bits(8))));
    load_word(8'h41, make_uword(2'b10, uaddr_t'(rand_bits(8))));
    predict_walk(8'h20);
    base       = seen_q.size();
    capture_on = 1'b1;
    apb_write(ctrl_addr, 16'h2001, e);           // Start at 0x20
    wait_running(1'b1, "start");
    wait_running(1'b0, "halt");
    @(negedge sysclk);
    capture_on = 1'b0;
    check_data(bus_data_t'(seen_q.size() - base), bus_data_t'(exp_q.size()),
               "number of microwords");
    for (i = 0; i < exp_q.size() && base + i < seen_q.size(); i++) begin
      check_word(seen_q[base + i], exp_q[i], "csbits");
    end
    apb_read(stat_addr, d, e);
    check_data(d, {exp_last, 8'h02}, "status after halt");
    end_test("program_walk");
  endtask

  task automatic test_locked_write();
    bus_data_t old_q0;
    bus_data_t d;
    logic      e;
    load_word(8'h60, make_uword(2'b01, 8'h60));  // Jumps to itself
    load_word(8'h61, make_uword(2'b10, uaddr_t'(rand_bits(8))));
    old_q0 = prog[8'h60][15:0];
    apb_write(ctrl_addr, 16'h6001, e);
    wait_running(1'b1, "start");
    apb_write(cs_addr(8'h60, 2'd0), ~old_q0, e);
    check_data({15'b0, e}, 16'h0001, "pslverr on write while running");
    check_data({15'b0, running}, 16'h0001, "running during loop");
    apb_write(ctrl_addr, 16'h6101, e);           // Restart on the halt word
    wait_running(1'b0, "halt");
    apb_read(cs_addr(8'h60, 2'd0), d, e);
    check_data(d, old_q0, "microword after refused write");
    check_data({15'b0, e}, '0, "pslverr on readback");
    apb_read(stat_addr, d, e);
    check_data(d, 16'h6102, "status after halt");
    end_test("locked_write");
  endtask

  initial begin
    arst_n       = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    la           = '0;
    lfsr_state   = 32'haa31a5e1;
    err_cnt      = 0;
    total_err    = 0;
    tests_run    = 0;
    tests_failed = 0;
    capture_on   = 1'b0;
    repeat (2) @(posedge sysclk);
    @(negedge sysclk);
    arst_n = 1'b1;
    test_reset_state();
    test_ram_readback();
    test_mmu_translate();
    test_program_walk();
    test_locked_write();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_err);
    if (total_err == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(wd_time);
    $display("Run stopped by the watchdog at %0t, a test is stuck", $time);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- vlog.f
source/nd_bus_pkg.sv
source/nd_cpu_pkg.sv
source/apb_ctrl_fsm.sv
source/micro_seq_counter.sv
source/control_store.sv
source/page_table_mmu.sv
source/cpu_core_top.sv
tests/tb_cpu_core.sv

//--- Makefile
# Verilator build and run for the CPU core testbench
SIM = obj_dir/sim_cpu_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module tb_cpu_core -o sim_cpu_core

run: compile
	./$(SIM) > sim.log; cat sim.log
	grep -q "^TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
